// File: soc_pkg.sv
// Shared widths, address map and sequencer states, imported by every RTL block and the testbench
package soc_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 64;
  localparam int unsigned DATA_BYTES = DATA_WIDTH / 8;
  localparam int unsigned ROM_WORDS  = 16;

  typedef logic [ADDR_WIDTH-1:0]        addr_t;
  typedef logic [DATA_WIDTH-1:0]        data_t;
  typedef logic [DATA_BYTES-1:0]        strb_t;
  typedef logic [$clog2(ROM_WORDS)-1:0] rom_idx_t;

  // ------------------------------
  // Address map
  // ------------------------------
  localparam addr_t ROM_BASE     = 32'h0001_0000;
  localparam addr_t ROM_LENGTH   = 32'd128;
  localparam addr_t CLINT_BASE   = 32'h0200_0000;
  localparam addr_t CLINT_LENGTH = 32'h0000_C000;

  // CLINT register byte offsets, one 64-bit word each
  localparam addr_t MSIP_OFFSET     = 32'h0000_0000;
  localparam addr_t MTIMECMP_OFFSET = 32'h0000_4000;
  localparam addr_t MTIME_OFFSET    = 32'h0000_BFF8;

  // Cycles the core debug request stays blocked after reset
  localparam int unsigned DEBUG_DELAY_DEFAULT = 500;

  // Access sequencer states
  typedef enum logic {
    IDLE = 1'b0,
    RESP = 1'b1
  } access_state_e;

  // Byte-enabled update of a data word
  function automatic data_t strb_merge(data_t old_val, data_t new_val, strb_t be);
    data_t res;
    res = old_val;
    for (int i = 0; i < DATA_BYTES; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

// File: periph_bus_if.sv
// Single-access target port between the sequencer and one peripheral, with master and target views
interface periph_bus_if;
  import soc_pkg::*;

  // Strobe and request fields, driven by the sequencer in the grant cycle
  logic  sel;
  logic  we;
  addr_t addr;
  strb_t be;
  data_t wdata;
  // Combinational read data from the target
  data_t rdata;

  modport master (
    output sel,
    output we,
    output addr,
    output be,
    output wdata,
    input  rdata
  );

  modport target (
    input  sel,
    input  we,
    input  addr,
    input  be,
    input  wdata,
    output rdata
  );

endinterface

// File: boot_rom.sv
// Boot ROM target: 16 fixed words that park the hart in a wait-for-interrupt loop
module boot_rom (
  periph_bus_if.target bus
);
  import soc_pkg::*;

  rom_idx_t idx;

  // Word index from the byte offset
  assign idx = bus.addr[3 +: $bits(rom_idx_t)];

  // Two instructions per word, lower half executes first
  always_comb begin
    case (idx)
      // csrr a0, mhartid ; auipc a1, 0
      4'd0:    bus.rdata = 64'h00000597_f1402573;
      // addi a1, a1, 60 ; csrci mstatus, 8
      4'd1:    bus.rdata = 64'h30047073_03c58593;
      // wfi ; j back to wfi
      4'd2:    bus.rdata = 64'hffdff06f_10500073;
      4'd3:    bus.rdata = 64'h00000013_00000013;
      // Device tree blob header that a1 points to
      4'd8:    bus.rdata = 64'h80000000_edfe0dd0;
      4'd9:    bus.rdata = 64'h28000000_38000000;
      4'd10:   bus.rdata = 64'h11000000_48000000;
      4'd11:   bus.rdata = 64'h00000000_10000000;
      default: bus.rdata = '0;
    endcase
  end

endmodule

// File: clint_timer.sv
// CLINT timer target: rtc edge counting, machine time, compare and software interrupt registers
module clint_timer (
  input  logic         clk_i,
  input  logic         ndmreset_n,
  input  logic         rtc_i,
  periph_bus_if.target bus,
  output logic         timer_irq_o,
  output logic         ipi_o
);
  import soc_pkg::*;

  logic [2:0] rtc_sync_q;
  logic       rtc_rise;
  logic       rtc_phase_q;
  logic       tick;
  addr_t      word_off;
  logic       wr_en;
  logic       msip_we;
  logic       mtimecmp_we;
  logic       mtime_we;
  data_t      msip_q;
  data_t      mtimecmp_q;
  data_t      mtime_q;

  // ------------------------------
  // RTC edge and divide by two
  // ------------------------------
  // Two sync stages, third stage for the edge
  assign rtc_rise = rtc_sync_q[1] && !rtc_sync_q[2];

  // Count only on edges where the phase bit was set
  assign tick = rtc_rise && rtc_phase_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q  <= '0;
      rtc_phase_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[1:0], rtc_i};
      if (rtc_rise) begin
        rtc_phase_q <= !rtc_phase_q;
      end
    end
  end

  // ------------------------------
  // Register decode
  // ------------------------------
  assign word_off    = {bus.addr[ADDR_WIDTH-1:3], 3'b000};
  assign wr_en       = bus.sel && bus.we;
  assign msip_we     = wr_en && (word_off == MSIP_OFFSET);
  assign mtimecmp_we = wr_en && (word_off == MTIMECMP_OFFSET);
  assign mtime_we    = wr_en && (word_off == MTIME_OFFSET);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q     <= '0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
    end else begin
      if (msip_we) begin
        msip_q <= strb_merge(msip_q, bus.wdata, bus.be);
      end
      if (mtimecmp_we) begin
        mtimecmp_q <= strb_merge(mtimecmp_q, bus.wdata, bus.be);
      end
      // Bus write wins over the tick; phase bit keeps running
      if (mtime_we) begin
        mtime_q <= strb_merge(mtime_q, bus.wdata, bus.be);
      end else if (tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
    end
  end

  // Read mux, unused offsets read as zero
  always_comb begin
    case (word_off)
      MSIP_OFFSET:     bus.rdata = msip_q;
      MTIMECMP_OFFSET: bus.rdata = mtimecmp_q;
      MTIME_OFFSET:    bus.rdata = mtime_q;
      default:         bus.rdata = '0;
    endcase
  end

  // ------------------------------
  // Interrupts
  // ------------------------------
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q[0];

endmodule

// File: debug_req_gate.sv
// Start-up window that blocks the core debug request for a fixed number of cycles after reset
module debug_req_gate #(
  parameter int unsigned DEBUG_DELAY = soc_pkg::DEBUG_DELAY_DEFAULT
) (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned CNT_WIDTH = (DEBUG_DELAY > 0) ? $clog2(DEBUG_DELAY + 1) : 1;

  logic [CNT_WIDTH-1:0] cnt_q;

  // Saturating down-counter, loaded by reset
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= CNT_WIDTH'(DEBUG_DELAY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Pass the request once the window has closed
  assign debug_req_o = (cnt_q == '0) ? debug_req_i : 1'b0;

endmodule

// File: access_fsm.sv
// Access sequencer: grants one request at a time, routes it by address and returns a registered response
module access_fsm (
  input  logic           clk_i,
  input  logic           ndmreset_n,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::strb_t be_i,
  input  soc_pkg::data_t wdata_i,
  output logic           gnt_o,
  output logic           rvalid_o,
  output logic           err_o,
  output soc_pkg::data_t rdata_o,
  periph_bus_if.master   rom_bus,
  periph_bus_if.master   clint_bus
);
  import soc_pkg::*;

  access_state_e state_q;
  access_state_e state_d;
  logic          rom_hit;
  logic          clint_hit;
  logic          rom_sel;
  logic          clint_sel;
  logic          err_q;
  data_t         rdata_d;
  data_t         rdata_q;

  // ------------------------------
  // Address decode
  // ------------------------------
  assign rom_hit   = (addr_i >= ROM_BASE) && (addr_i < ROM_BASE + ROM_LENGTH);
  assign clint_hit = (addr_i >= CLINT_BASE) && (addr_i < CLINT_BASE + CLINT_LENGTH);

  // No grant while the response is out
  assign gnt_o = (state_q == IDLE) && req_i;

  // ROM is read-only, writes there take the error path
  assign rom_sel   = gnt_o && rom_hit && !we_i;
  assign clint_sel = gnt_o && clint_hit;

  // Target strobes, addresses as offsets from each base
  assign rom_bus.sel   = rom_sel;
  assign rom_bus.we    = we_i;
  assign rom_bus.addr  = addr_i - ROM_BASE;
  assign rom_bus.be    = be_i;
  assign rom_bus.wdata = wdata_i;

  assign clint_bus.sel   = clint_sel;
  assign clint_bus.we    = we_i;
  assign clint_bus.addr  = addr_i - CLINT_BASE;
  assign clint_bus.be    = be_i;
  assign clint_bus.wdata = wdata_i;

  // Writes and errors answer with zero
  always_comb begin
    rdata_d = '0;
    if (rom_sel) begin
      rdata_d = rom_bus.rdata;
    end else if (clint_sel && !we_i) begin
      rdata_d = clint_bus.rdata;
    end
  end

  // ------------------------------
  // Sequencer
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          state_d = RESP;
        end
      end
      RESP:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      state_q <= IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // Granted but no target took it
      err_q   <= gnt_o && !(rom_sel || clint_sel);
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      rdata_q <= rdata_d;
    end
  end

  assign rvalid_o = (state_q == RESP);
  assign err_o    = err_q;
  assign rdata_o  = rdata_q;

endmodule

// File: soc_ctrl_subsys.sv
// Control slice top level: access sequencer, boot ROM, CLINT timer and debug request gate
module soc_ctrl_subsys #(
  parameter int unsigned DEBUG_DELAY = soc_pkg::DEBUG_DELAY_DEFAULT
) (
  input  logic           clk_i,
  input  logic           ndmreset_n,
  // Register access port
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::strb_t be_i,
  input  soc_pkg::data_t wdata_i,
  output logic           gnt_o,
  output logic           rvalid_o,
  output soc_pkg::data_t rdata_o,
  output logic           err_o,
  // Real-time clock and interrupts
  input  logic           rtc_i,
  output logic           timer_irq_o,
  output logic           ipi_o,
  // Debug request to the core
  input  logic           debug_req_i,
  output logic           debug_req_o
);

  periph_bus_if rom_bus ();
  periph_bus_if clint_bus ();

  // ------------------------------
  // Sequencer and targets
  // ------------------------------
  access_fsm u_access_fsm (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .req_i      ( req_i      ),
    .we_i       ( we_i       ),
    .addr_i     ( addr_i     ),
    .be_i       ( be_i       ),
    .wdata_i    ( wdata_i    ),
    .gnt_o      ( gnt_o      ),
    .rvalid_o   ( rvalid_o   ),
    .err_o      ( err_o      ),
    .rdata_o    ( rdata_o    ),
    .rom_bus    ( rom_bus    ),
    .clint_bus  ( clint_bus  )
  );

  boot_rom u_boot_rom (
    .bus ( rom_bus )
  );

  clint_timer u_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .bus         ( clint_bus   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // ------------------------------
  // Debug start-up window
  // ------------------------------
  debug_req_gate #(
    .DEBUG_DELAY ( DEBUG_DELAY )
  ) u_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: soc_ctrl_subsys_chk.sv
// Access port and debug gate assertions, bound into the control slice top level during simulation
module soc_ctrl_subsys_chk (
  input logic clk_i,
  input logic ndmreset_n,
  input logic gnt_o,
  input logic rvalid_o,
  input logic err_o,
  input logic debug_req_i,
  input logic debug_req_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------
  // Response timing
  // ------------------------------
  gnt_then_rvalid: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    gnt_o |=> rvalid_o)
    else $error("A grant was not followed by a response on the next cycle");

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    rvalid_o |-> $past(gnt_o))
    else $error("A response came without a grant in the cycle before");

  // No grant while the response is out
  no_gnt_in_resp: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !(gnt_o && rvalid_o))
    else $error("Grant and response were high in the same cycle");

  err_with_rvalid: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    err_o |-> rvalid_o)
    else $error("Error flag was high outside a response cycle");

  // Gate can only block, never create a request
  debug_req_passed: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    debug_req_o |-> debug_req_i)
    else $error("Debug request to the core was high without an incoming request");

endmodule

bind soc_ctrl_subsys soc_ctrl_subsys_chk u_chk (
  .clk_i       ( clk_i       ),
  .ndmreset_n  ( ndmreset_n  ),
  .gnt_o       ( gnt_o       ),
  .rvalid_o    ( rvalid_o    ),
  .err_o       ( err_o       ),
  .debug_req_i ( debug_req_i ),
  .debug_req_o ( debug_req_o )
);

// File: tb_soc_ctrl_subsys.sv
// Testbench for the control slice: drives accesses and rtc, checks against a reference model
module tb_soc_ctrl_subsys;
  timeunit 1ns;
  timeprecision 100ps;
  import soc_pkg::*;

  localparam int unsigned DELAY       = 40;
  localparam int unsigned RTC_HALF    = 3;
  localparam int unsigned WAIT_LIMIT  = 20;
  // About 700 cycles of tests at 8 ns, with a wide margin
  localparam int unsigned WATCHDOG_NS = 40000;

  logic  clk_i;
  logic  ndmreset_n;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  strb_t be_i;
  data_t wdata_i;
  logic  gnt_o;
  logic  rvalid_o;
  data_t rdata_o;
  logic  err_o;
  logic  rtc_i;
  logic  timer_irq_o;
  logic  ipi_o;
  logic  debug_req_i;
  logic  debug_req_o;

  // Reference model
  data_t       rom_table [ROM_WORDS];
  data_t       ref_msip;
  data_t       ref_mtimecmp;
  data_t       ref_mtime;
  int unsigned rtc_edges;
  logic [31:0] rng_state;
  data_t       exp_data_q [$];
  logic        exp_err_q [$];

  soc_ctrl_subsys #(
    .DEBUG_DELAY ( DELAY )
  ) dut0 (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .be_i        ( be_i        ),
    .wdata_i     ( wdata_i     ),
    .gnt_o       ( gnt_o       ),
    .rvalid_o    ( rvalid_o    ),
    .rdata_o     ( rdata_o     ),
    .err_o       ( err_o       ),
    .rtc_i       ( rtc_i       ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_NS);
    stop_run("Timeout: the tests did not finish in time");
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t be);
    data_t mask;
    for (int i = 0; i < 8; i++) begin
      mask[8*i +: 8] = {8{be[i]}};
    end
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  // Expected response of one access, from the model state
  function automatic data_t ref_access(addr_t addr, logic we, output logic err);
    addr_t off;
    err = 1'b0;
    if (addr >= ROM_BASE && addr < ROM_BASE + ROM_LENGTH) begin
      off = addr - ROM_BASE;
      err = we;
      return we ? '0 : rom_table[off[6:3]];
    end
    if (addr >= CLINT_BASE && addr < CLINT_BASE + CLINT_LENGTH) begin
      off = (addr - CLINT_BASE) & ~32'h7;
      if (we) return '0;
      if (off == MSIP_OFFSET) return ref_msip;
      if (off == MTIMECMP_OFFSET) return ref_mtimecmp;
      if (off == MTIME_OFFSET) return ref_mtime;
      return '0;
    end
    err = 1'b1;
    return '0;
  endfunction

  task automatic model_write(addr_t addr, strb_t be, data_t wdata);
    addr_t off;
    off = (addr - CLINT_BASE) & ~32'h7;
    if (off == MSIP_OFFSET) ref_msip = merge_bytes(ref_msip, wdata, be);
    if (off == MTIMECMP_OFFSET) ref_mtimecmp = merge_bytes(ref_mtimecmp, wdata, be);
    if (off == MTIME_OFFSET) ref_mtime = merge_bytes(ref_mtime, wdata, be);
  endtask

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // One access: wait for the grant, log the expectation, wait for the response
  task automatic bus_access(logic we, addr_t addr, strb_t be, data_t wdata);
    logic        err;
    data_t       exp;
    int unsigned waited;
    @(negedge clk_i);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
    waited  = 0;
    #1;
    while (!gnt_o) begin
      waited++;
      if (waited > WAIT_LIMIT) stop_run("No grant arrived for a pending request");
      @(negedge clk_i);
      #1;
    end
    exp = ref_access(addr, we, err);
    exp_data_q.push_back(exp);
    exp_err_q.push_back(err);
    if (we && !err) model_write(addr, be, wdata);
    @(negedge clk_i);
    req_i  = 1'b0;
    waited = 0;
    while (!rvalid_o) begin
      waited++;
      if (waited > WAIT_LIMIT) stop_run("No response arrived after a grant");
      @(negedge clk_i);
    end
  endtask

  // Full rtc periods, the model counts every rising edge
  task automatic run_rtc(int unsigned periods);
    repeat (periods) begin
      @(negedge clk_i);
      rtc_i = 1'b1;
      rtc_edges++;
      if (rtc_edges % 2 == 0) ref_mtime++;
      repeat (RTC_HALF) @(negedge clk_i);
      rtc_i = 1'b0;
      repeat (RTC_HALF - 1) @(negedge clk_i);
    end
  endtask

  // Compare every response with the oldest expectation
  always @(negedge clk_i) begin
    if (ndmreset_n && rvalid_o) begin
      if (exp_data_q.size() == 0) stop_run("A response came with no request pending");
      check_data("rdata_o", rdata_o, exp_data_q.pop_front());
      check_bit("err_o", err_o, exp_err_q.pop_front());
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    addr_t       addr;
    data_t       value;
    logic [31:0] rnd;
    logic        err;
    int unsigned start;
    int unsigned step;
    rng_state    = 32'h54a3;
    rtc_edges    = 0;
    ref_msip     = '0;
    ref_mtimecmp = '1;
    ref_mtime    = '0;
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom_table[i] = '0;
    end
    rom_table[0]  = 64'h00000597_f1402573;
    rom_table[1]  = 64'h30047073_03c58593;
    rom_table[2]  = 64'hffdff06f_10500073;
    rom_table[3]  = 64'h00000013_00000013;
    rom_table[8]  = 64'h80000000_edfe0dd0;
    rom_table[9]  = 64'h28000000_38000000;
    rom_table[10] = 64'h11000000_48000000;
    rom_table[11] = 64'h00000000_10000000;
    ndmreset_n  = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    be_i        = '0;
    wdata_i     = '0;
    rtc_i       = 1'b0;
    debug_req_i = 1'b1;
    repeat (3) @(negedge clk_i);
    ndmreset_n = 1'b1;

    // Reset values and the debug start-up window
    check_bit("gnt_o", gnt_o, 1'b0);
    check_bit("rvalid_o", rvalid_o, 1'b0);
    check_bit("err_o", err_o, 1'b0);
    check_bit("timer_irq_o", timer_irq_o, 1'b0);
    check_bit("ipi_o", ipi_o, 1'b0);
    check_bit("debug_req_o", debug_req_o, 1'b0);
    for (int i = 1; i <= DELAY + 4; i++) begin
      @(negedge clk_i);
      check_bit("debug_req_o", debug_req_o, i >= DELAY);
    end
    repeat (8) begin
      rnd = next_random();
      debug_req_i = rnd[0];
      @(negedge clk_i);
      check_bit("debug_req_o", debug_req_o, debug_req_i);
    end

    // ROM reads in a random order, odd step covers every word
    start = next_random() % ROM_WORDS;
    step  = 2 * (next_random() % 8) + 1;
    for (int i = 0; i < ROM_WORDS; i++) begin
      addr = ROM_BASE + addr_t'(((start + i * step) % ROM_WORDS) * 8 + next_random() % 8);
      bus_access(1'b0, addr, strb_t'(next_random()), '0);
    end

    // Error paths, then reads that show nothing changed
    addr = ROM_BASE + addr_t'((next_random() % ROM_WORDS) * 8);
    bus_access(1'b1, addr, '1, {next_random(), next_random()});
    bus_access(1'b0, addr, '1, '0);
    repeat (6) begin
      addr  = next_random();
      value = ref_access(addr, 1'b0, err);
      while (!err) begin
        addr  = next_random();
        value = ref_access(addr, 1'b0, err);
      end
      rnd = next_random();
      bus_access(rnd[0], addr, strb_t'(rnd[15:8]), {next_random(), next_random()});
    end
    bus_access(1'b0, CLINT_BASE + MSIP_OFFSET, '1, '0);
    bus_access(1'b0, CLINT_BASE + MTIMECMP_OFFSET, '1, '0);

    // Software interrupt register with byte enables
    repeat (8) begin
      bus_access(1'b1, CLINT_BASE + MSIP_OFFSET, strb_t'(next_random()),
                 {next_random(), next_random()});
      check_bit("ipi_o", ipi_o, ref_msip[0]);
      bus_access(1'b0, CLINT_BASE + MSIP_OFFSET, '1, '0);
    end

    // Machine time against rtc edges
    repeat (6) begin
      bus_access(1'b1, CLINT_BASE + MTIME_OFFSET, '1, {next_random(), next_random()});
      run_rtc(1 + next_random() % 8);
      bus_access(1'b0, CLINT_BASE + MTIME_OFFSET, '1, '0);
    end

    // Timer interrupt as mtime passes the compare value
    bus_access(1'b1, CLINT_BASE + MTIME_OFFSET, '1, {32'h0, next_random()});
    bus_access(1'b1, CLINT_BASE + MTIMECMP_OFFSET, '1, ref_mtime + 2 + next_random() % 2);
    repeat (8) begin
      check_bit("timer_irq_o", timer_irq_o, ref_mtime >= ref_mtimecmp);
      bus_access(1'b0, CLINT_BASE + MTIME_OFFSET, '1, '0);
      run_rtc(1);
    end
    check_bit("timer_irq_o", timer_irq_o, 1'b1);

    repeat (4) @(negedge clk_i);
    if (exp_data_q.size() != 0) stop_run("Some responses never arrived");
    $display("** PASS **");
    $finish;
  end

endmodule

// File: soc_ctrl_subsys.f
soc_pkg.sv
periph_bus_if.sv
boot_rom.sv
clint_timer.sv
debug_req_gate.sv
access_fsm.sv
soc_ctrl_subsys.sv
soc_ctrl_subsys_chk.sv
tb_soc_ctrl_subsys.sv

// File: run.sh
#!/usr/bin/env bash
# Build the control slice testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_soc_ctrl_subsys -Mdir obj_dir -f soc_ctrl_subsys.f

./obj_dir/Vtb_soc_ctrl_subsys > sim.log 2>&1 || true
cat sim.log

if grep -Fqx '** PASS **' sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
